// ==== hdl/cart_macros.svh ====
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

// Flat ROM/SRAM address out of the mappers
`define CART_ADDR_W   27

// Cartridge slots served by each mapper
`define CART_SLOTS    2

// APB address width
`define APB_ADDR_W    8

// Register offsets inside one slot group, slot number in paddr[4]
`define CFG_TYPE_OFS  4'h0
`define CFG_ROM_OFS   4'h4
`define CFG_SRAM_OFS  4'h8

// Bank value that swaps a window over to SRAM
`define SRAM_EN_CODE  8'h10

`endif // CART_MACROS_SVH

// ==== hdl/cart_cfg_pkg.sv ====
`default_nettype none

package cart_cfg_pkg;

    // Mapper kinds held per slot
    typedef enum logic [2:0] {
        MAPPER_NONE    = 3'd0,   // Slot empty or unmapped
        MAPPER_ASCII8  = 3'd1,   // Four 8 KB windows
        MAPPER_ASCII16 = 3'd2,   // Two 16 KB windows
        MAPPER_RTYPE   = 3'd3    // ASCII16 variant, fixed lower window
    } mapper_t;

    // Configuration handed to the mappers for the active slot
    typedef struct packed {
        mapper_t     typ;        // Mapper kind
        logic [24:0] rom_size;   // ROM size in bytes
        logic [15:0] sram_size;  // SRAM size in KB
        logic        id;         // Slot, picks the bank register set
    } block_info_t;

endpackage

`default_nettype wire

// ==== hdl/cart_bus_pkg.sv ====
`default_nettype none

`include "cart_macros.svh"

package cart_bus_pkg;

    // One CPU memory access, plain strobes
    typedef struct packed {
        logic [15:0] addr;       // Z80 address
        logic [7:0]  data;       // Write data
        logic        mreq;       // Memory request
        logic        rd;         // Read strobe
        logic        wr;         // Write strobe
        logic        slot;       // Target cartridge slot
    } cpu_req_t;

    // Mapper result toward the memories
    typedef struct packed {
        logic [`CART_ADDR_W-1:0] addr;   // Flat ROM or SRAM address
        logic                    ram_cs; // ROM select
        logic                    sram_cs;
        logic                    rnw;    // Low only for SRAM writes
    } mapper_out_t;

    // APB request side
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    // APB response side
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;    // Unmapped register
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/cart_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cart_macros.svh"

module cart_cfg_regs (
    input  wire logic                    clock_bus,
    input  wire logic                    rst,
    input  wire cart_bus_pkg::apb_req_t  apb_req,
    output cart_bus_pkg::apb_rsp_t       apb_rsp,
    input  wire logic                    slot,       // Slot of the current CPU access
    output cart_cfg_pkg::block_info_t    block_info
);

    // Per-slot configuration registers
    cart_cfg_pkg::mapper_t typ_q  [`CART_SLOTS];
    logic [24:0]           rom_q  [`CART_SLOTS];
    logic [15:0]           sram_q [`CART_SLOTS];

    logic       apb_slot;        // Slot group addressed over APB
    logic [3:0] reg_ofs;         // Offset inside the group
    logic       upper_ok;        // paddr[7:5] must be clear
    logic       sel_type;
    logic       sel_rom;
    logic       sel_sram;
    logic       reg_hit;         // One of the six registers
    logic       access;          // APB access phase
    logic       wr_en;
    logic [31:0] rdata;

    assign apb_slot = apb_req.paddr[4];
    assign reg_ofs  = apb_req.paddr[3:0];
    assign upper_ok = (apb_req.paddr[`APB_ADDR_W-1:5] == '0);

    // Offset decode
    assign sel_type = upper_ok && (reg_ofs == `CFG_TYPE_OFS);
    assign sel_rom  = upper_ok && (reg_ofs == `CFG_ROM_OFS);
    assign sel_sram = upper_ok && (reg_ofs == `CFG_SRAM_OFS);
    assign reg_hit  = sel_type | sel_rom | sel_sram;

    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite & reg_hit;   // Unmapped writes dropped

    // Register write at the end of the access phase
    always_ff @(posedge clock_bus) begin
        if (rst) begin
            for (int s = 0; s < `CART_SLOTS; s++) begin
                typ_q[s]  <= cart_cfg_pkg::MAPPER_NONE;
                rom_q[s]  <= '0;
                sram_q[s] <= '0;
            end
        end else if (wr_en) begin
            if (sel_type)
                typ_q[apb_slot] <= cart_cfg_pkg::mapper_t'(apb_req.pwdata[2:0]);
            if (sel_rom)
                rom_q[apb_slot] <= apb_req.pwdata[24:0];   // Bytes
            if (sel_sram)
                sram_q[apb_slot] <= apb_req.pwdata[15:0];  // KB
        end
    end

    // Read mux
    always_comb begin
        rdata = '0;
        if (sel_type)
            rdata = {29'd0, typ_q[apb_slot]};
        else if (sel_rom)
            rdata = {7'd0, rom_q[apb_slot]};
        else if (sel_sram)
            rdata = {16'd0, sram_q[apb_slot]};
    end

    // Zero wait states, data only while reading a real register
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & ~reg_hit;
    assign apb_rsp.prdata  = (access & ~apb_req.pwrite & reg_hit) ? rdata : 32'd0;

    // Configuration of the slot the CPU is addressing
    assign block_info.typ       = typ_q[slot];
    assign block_info.rom_size  = rom_q[slot];
    assign block_info.sram_size = sram_q[slot];
    assign block_info.id        = slot;

    // Setup phase must be followed by an access phase to the same address
    apb_setup_to_access: assert property (
        @(posedge clock_bus) disable iff (rst)
        (apb_req.psel && !apb_req.penable) |=>
            (apb_req.psel && apb_req.penable && $stable(apb_req.paddr))
    ) else $error("APB setup not followed by a stable access phase");

endmodule

`default_nettype wire

// ==== hdl/mapper_ascii16.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cart_macros.svh"

module mapper_ascii16 (
    input  wire logic                       clock_bus,
    input  wire logic                       rst,
    input  wire cart_bus_pkg::cpu_req_t     cpu_req,
    input  wire cart_cfg_pkg::block_info_t  block_info,
    output cart_bus_pkg::mapper_out_t       out
);

    localparam int AW = `CART_ADDR_W;

    logic mapped;                // 0x4000-0xBFFF
    logic mapper_en;
    logic mode_rtype;
    logic cs;
    logic sram_exists;

    // Banks and SRAM enables, one set per slot
    logic [7:0] bank0_q   [`CART_SLOTS];
    logic [7:0] bank1_q   [`CART_SLOTS];
    logic [1:0] sram_en_q [`CART_SLOTS];   // Bit per window

    logic [7:0]    bank_base;
    logic          sram_en;
    logic [AW-1:0] sram_addr;
    logic [AW-1:0] ram_addr;
    logic          ram_valid;
    logic          ram_cs;
    logic          sram_cs;

    assign mapped      = ^cpu_req.addr[15:14];   // 01 or 10
    assign mode_rtype  = (block_info.typ == cart_cfg_pkg::MAPPER_RTYPE);
    assign mapper_en   = (block_info.typ == cart_cfg_pkg::MAPPER_ASCII16) | mode_rtype;
    assign cs          = mapped & mapper_en & cpu_req.mreq;
    assign sram_exists = (block_info.sram_size != 16'd0);

    // Bank register writes
    always_ff @(posedge clock_bus) begin
        if (rst) begin
            for (int s = 0; s < `CART_SLOTS; s++) begin
                bank0_q[s]   <= 8'h00;
                bank1_q[s]   <= 8'h00;
                sram_en_q[s] <= 2'b00;
            end
        end else if (cs & cpu_req.wr) begin
            if (mode_rtype) begin
                // R-TYPE only answers at 0x7000-0x7FFF
                if (cpu_req.addr[15:12] == 4'b0111)
                    bank1_q[block_info.id] <= cpu_req.data &
                                              (cpu_req.data[4] ? 8'h17 : 8'h1F);
            end else begin
                case (cpu_req.addr[15:11])
                    5'b01100: begin   // 0x6000-0x67FF
                        if (cpu_req.data == `SRAM_EN_CODE && sram_exists) begin
                            sram_en_q[block_info.id][0] <= 1'b1;
                        end else begin
                            sram_en_q[block_info.id][0] <= 1'b0;
                            bank0_q[block_info.id]      <= cpu_req.data;
                        end
                    end
                    5'b01110: begin   // 0x7000-0x77FF
                        if (cpu_req.data == `SRAM_EN_CODE && sram_exists) begin
                            sram_en_q[block_info.id][1] <= 1'b1;
                        end else begin
                            sram_en_q[block_info.id][1] <= 1'b0;
                            bank1_q[block_info.id]      <= cpu_req.data;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Upper window uses bank1, lower one is pinned to 0x0F in R-TYPE
    assign bank_base = cpu_req.addr[15] ? bank1_q[block_info.id] :
                       (mode_rtype ? 8'h0F : bank0_q[block_info.id]);
    assign sram_en   = sram_en_q[block_info.id][cpu_req.addr[15]];

    // 8 KB SRAM image above 2 KB, else 2 KB mirrored
    assign sram_addr = (block_info.sram_size > 16'd2) ?
                       {{(AW-13){1'b0}}, cpu_req.addr[12:0]} :
                       {{(AW-11){1'b0}}, cpu_req.addr[10:0]};
    assign ram_addr  = {{(AW-22){1'b0}}, bank_base, cpu_req.addr[13:0]};
    assign ram_valid = (ram_addr < {{(AW-25){1'b0}}, block_info.rom_size});

    assign sram_cs = cs & sram_en;
    assign ram_cs  = cs & ram_valid & ~sram_en & cpu_req.rd;

    assign out.ram_cs  = ram_cs;
    assign out.sram_cs = sram_cs;
    assign out.rnw     = ~(sram_cs & cpu_req.wr & cpu_req.addr[15]);
    assign out.addr    = cs ? (sram_en ? sram_addr : ram_addr) : {AW{1'b1}};   // Idle all ones

    // ROM and SRAM must never be selected together
    ascii16_cs_excl: assert property (
        @(posedge clock_bus) disable iff (rst) !(out.ram_cs && out.sram_cs)
    ) else $error("ASCII16 drives ram_cs and sram_cs together");

endmodule

`default_nettype wire

// ==== hdl/mapper_ascii8.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cart_macros.svh"

module mapper_ascii8 (
    input  wire logic                       clock_bus,
    input  wire logic                       rst,
    input  wire cart_bus_pkg::cpu_req_t     cpu_req,
    input  wire cart_cfg_pkg::block_info_t  block_info,
    output cart_bus_pkg::mapper_out_t       out
);

    localparam int AW = `CART_ADDR_W;

    logic       mapped;
    logic       mapper_en;
    logic       cs;
    logic       sram_exists;
    logic [1:0] win;             // 8 KB window being read
    logic       bank_wr;         // Write inside 0x6000-0x7FFF
    logic [1:0] wr_idx;          // Bank register picked by the write

    // Four banks per slot
    logic [7:0] bank_q    [`CART_SLOTS][4];
    logic [3:0] sram_en_q [`CART_SLOTS];

    logic [7:0]    bank_base;
    logic          sram_en;
    logic [AW-1:0] sram_addr;
    logic [AW-1:0] ram_addr;
    logic          ram_valid;
    logic          ram_cs;
    logic          sram_cs;

    assign mapped      = ^cpu_req.addr[15:14];
    assign mapper_en   = (block_info.typ == cart_cfg_pkg::MAPPER_ASCII8);
    assign cs          = mapped & mapper_en & cpu_req.mreq;
    assign sram_exists = (block_info.sram_size != 16'd0);

    // 0x4000 -> 0, 0x6000 -> 1, 0x8000 -> 2, 0xA000 -> 3
    assign win = {cpu_req.addr[15], cpu_req.addr[13]};

    // 0x6000, 0x6800, 0x7000, 0x7800, each 2 KB
    assign bank_wr = cs & cpu_req.wr & (cpu_req.addr[15:13] == 3'b011);
    assign wr_idx  = cpu_req.addr[12:11];

    always_ff @(posedge clock_bus) begin
        if (rst) begin
            for (int s = 0; s < `CART_SLOTS; s++) begin
                for (int b = 0; b < 4; b++)
                    bank_q[s][b] <= 8'h00;
                sram_en_q[s] <= 4'h0;
            end
        end else if (bank_wr) begin
            if (cpu_req.data == `SRAM_EN_CODE && sram_exists) begin
                sram_en_q[block_info.id][wr_idx] <= 1'b1;   // Window now SRAM
            end else begin
                sram_en_q[block_info.id][wr_idx] <= 1'b0;
                bank_q[block_info.id][wr_idx]    <= cpu_req.data;
            end
        end
    end

    assign bank_base = bank_q[block_info.id][win];
    assign sram_en   = sram_en_q[block_info.id][win];

    // Same SRAM address rule as ASCII16
    assign sram_addr = (block_info.sram_size > 16'd2) ?
                       {{(AW-13){1'b0}}, cpu_req.addr[12:0]} :
                       {{(AW-11){1'b0}}, cpu_req.addr[10:0]};
    assign ram_addr  = {{(AW-21){1'b0}}, bank_base, cpu_req.addr[12:0]};   // 13-bit offset
    assign ram_valid = (ram_addr < {{(AW-25){1'b0}}, block_info.rom_size});

    assign sram_cs = cs & sram_en;
    assign ram_cs  = cs & ram_valid & ~sram_en & cpu_req.rd;

    // SRAM writable only in windows 2 and 3
    assign out.ram_cs  = ram_cs;
    assign out.sram_cs = sram_cs;
    assign out.rnw     = ~(sram_cs & cpu_req.wr & cpu_req.addr[15]);
    assign out.addr    = cs ? (sram_en ? sram_addr : ram_addr) : {AW{1'b1}};

    ascii8_cs_excl: assert property (
        @(posedge clock_bus) disable iff (rst) !(out.ram_cs && out.sram_cs)
    ) else $error("ASCII8 drives ram_cs and sram_cs together");

endmodule

`default_nettype wire

// ==== hdl/cart_slot_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_slot_top (
    input  wire logic                    clock_bus,
    input  wire logic                    rst,
    input  wire cart_bus_pkg::apb_req_t  apb_req,
    output cart_bus_pkg::apb_rsp_t       apb_rsp,
    input  wire cart_bus_pkg::cpu_req_t  cpu_req,
    output cart_bus_pkg::mapper_out_t    out
);

    // Configuration of the slot in cpu_req.slot
    cart_cfg_pkg::block_info_t block_info;

    // Per-mapper results, idle value is all ones on addr and rnw
    cart_bus_pkg::mapper_out_t out_a16;
    cart_bus_pkg::mapper_out_t out_a8;

    cart_cfg_regs u_cfg_regs (
        .clock_bus  (clock_bus),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .slot       (cpu_req.slot),
        .block_info (block_info)
    );

    // ASCII16 and R-TYPE
    mapper_ascii16 u_ascii16 (
        .clock_bus  (clock_bus),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .block_info (block_info),
        .out        (out_a16)
    );

    mapper_ascii8 u_ascii8 (
        .clock_bus  (clock_bus),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .block_info (block_info),
        .out        (out_a8)
    );

    // Only one mapper is active per access, the other sits idle
    assign out.ram_cs  = out_a16.ram_cs  | out_a8.ram_cs;
    assign out.sram_cs = out_a16.sram_cs | out_a8.sram_cs;
    assign out.rnw     = out_a16.rnw     & out_a8.rnw;
    assign out.addr    = out_a16.addr    & out_a8.addr;   // All ones is neutral

endmodule

`default_nettype wire

// ==== bench/cart_slot_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cart_macros.svh"

module cart_slot_tb;

    localparam int RESET_CYCLES = 5;

    // One parsed line of the test file
    typedef struct packed {
        logic                    is_apb;      // APB line, else CPU line
        logic [`APB_ADDR_W-1:0]  paddr;
        logic [31:0]             pwdata;
        logic                    pwrite;
        logic [31:0]             exp_rdata;
        logic                    exp_slverr;
        logic                    slot;
        logic [15:0]             addr;
        logic [7:0]              data;
        logic                    rd;
        logic                    wr;
        logic [`CART_ADDR_W-1:0] exp_addr;
        logic                    exp_ram_cs;
        logic                    exp_sram_cs;
        logic                    exp_rnw;
    } test_line_t;

    logic                      clock_bus;
    logic                      rst;
    cart_bus_pkg::apb_req_t    apb_req;
    cart_bus_pkg::apb_rsp_t    apb_rsp;
    cart_bus_pkg::cpu_req_t    cpu_req;
    cart_bus_pkg::mapper_out_t map_out;

    test_line_t  tests[$];
    int unsigned line_count;     // Every file line, comments too
    int unsigned cycle_count;
    int unsigned cycle_limit;

    cart_slot_top dut (
        .clock_bus (clock_bus),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cpu_req   (cpu_req),
        .out       (map_out)
    );

    initial begin
        clock_bus = 1'b0;
        forever #10 clock_bus = ~clock_bus;   // 20 ns period
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Runaway guard, limit set once the file is loaded
    always @(posedge clock_bus) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
            abort_run("timeout: the tests ran past their cycle limit");
    end

    task automatic load_tests();
        int               fd;
        int               n;
        logic [8*128-1:0] line_buf;
        logic [7:0]       tok;       // Line kind, A or C
        logic [31:0]      v [9];
        test_line_t       t;
        fd = $fopen("bench/cart_slot_tests.txt", "r");
        if (fd == 0)
            abort_run("cannot open bench/cart_slot_tests.txt");
        while (!$feof(fd)) begin
            line_buf = '0;
            if ($fgets(line_buf, fd) > 0) begin
                line_count++;
                tok = 8'h00;
                t   = '0;
                n   = $sscanf(line_buf, "%s", tok);
                if (n == 1 && tok == "A") begin
                    n = $sscanf(line_buf, "%s %h %h %h %h %h", tok,
                                v[0], v[1], v[2], v[3], v[4]);
                    if (n != 6)
                        abort_run("malformed APB line in the test file");
                    t.is_apb     = 1'b1;
                    t.paddr      = v[0][`APB_ADDR_W-1:0];
                    t.pwdata     = v[1];
                    t.pwrite     = v[2][0];
                    t.exp_rdata  = v[3];
                    t.exp_slverr = v[4][0];
                    tests.push_back(t);
                end else if (n == 1 && tok == "C") begin
                    n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h", tok,
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                    if (n != 10)
                        abort_run("malformed CPU line in the test file");
                    t.slot        = v[0][0];
                    t.addr        = v[1][15:0];
                    t.data        = v[2][7:0];
                    t.rd          = v[3][0];
                    t.wr          = v[4][0];
                    t.exp_addr    = v[5][`CART_ADDR_W-1:0];
                    t.exp_ram_cs  = v[6][0];
                    t.exp_sram_cs = v[7][0];
                    t.exp_rnw     = v[8][0];
                    tests.push_back(t);
                end else if (n == 1 && tok != "#") begin
                    abort_run("unknown line kind in the test file");
                end
            end
        end
        $fclose(fd);
    endtask

    // Entered on a falling edge, leaves on the one after the access phase
    task automatic apb_access(input test_line_t t, input int idx);
        apb_req.psel    = 1'b1;           // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = t.pwrite;
        apb_req.paddr   = t.paddr;
        apb_req.pwdata  = t.pwdata;
        @(negedge clock_bus);
        apb_req.penable = 1'b1;           // Access phase, zero wait states
        #5;
        check_value(32'(apb_rsp.pready), 32'd1, $sformatf("entry %0d pready", idx));
        check_value(32'(apb_rsp.pslverr), 32'(t.exp_slverr),
                    $sformatf("entry %0d pslverr", idx));
        check_value(apb_rsp.prdata, t.exp_rdata, $sformatf("entry %0d prdata", idx));
        @(negedge clock_bus);             // Register write lands on the edge in between
        apb_req = '0;
    endtask

    task automatic cpu_access(input test_line_t t, input int idx);
        cpu_req.slot = t.slot;
        cpu_req.addr = t.addr;
        cpu_req.data = t.data;
        cpu_req.rd   = t.rd;
        cpu_req.wr   = t.wr;
        cpu_req.mreq = 1'b1;
        #5;                               // Zero-latency result, mid low phase
        check_value(32'(map_out.addr), 32'(t.exp_addr), $sformatf("entry %0d addr", idx));
        check_value(32'(map_out.ram_cs), 32'(t.exp_ram_cs),
                    $sformatf("entry %0d ram_cs", idx));
        check_value(32'(map_out.sram_cs), 32'(t.exp_sram_cs),
                    $sformatf("entry %0d sram_cs", idx));
        check_value(32'(map_out.rnw), 32'(t.exp_rnw), $sformatf("entry %0d rnw", idx));
        @(negedge clock_bus);             // Bank write commits on the rising edge
        cpu_req = '0;
    endtask

    initial begin
        int unsigned idle;
        rst     = 1'b1;
        apb_req = '0;
        cpu_req = '0;
        void'($urandom(45363));
        load_tests();
        cycle_limit = 8 * line_count + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clock_bus);
        @(negedge clock_bus);
        rst = 1'b0;
        foreach (tests[i]) begin
            if (tests[i].is_apb)
                apb_access(tests[i], i);
            else
                cpu_access(tests[i], i);
            idle = $urandom_range(3);     // Idle gap, results do not depend on it
            repeat (idle) @(negedge clock_bus);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cart_slot_tests.txt ====
# A paddr pwdata write exp_prdata exp_pslverr
# C slot addr data rd wr exp_addr exp_ram_cs exp_sram_cs exp_rnw
C 0 4000 00 1 0 7ffffff 0 0 1
A 00 00000002 1 00000000 0
A 04 00080000 1 00000000 0
A 10 00000001 1 00000000 0
A 14 00020000 1 00000000 0
A 18 00000008 1 00000000 0
A 04 00000000 0 00080000 0
A 18 00000000 0 00000008 0
A 0c 00000000 0 00000000 1
C 0 6000 03 0 1 0002000 0 0 1
C 0 7000 05 0 1 000f000 0 0 1
C 0 4123 00 1 0 000c123 1 0 1
C 0 bfff 00 1 0 0017fff 1 0 1
C 0 6000 10 0 1 000e000 0 0 1
C 0 4000 00 1 0 0040000 1 0 1
A 08 00000002 1 00000000 0
C 0 7000 10 0 1 0043000 0 0 1
C 0 8f45 55 0 1 0000745 0 1 0
C 0 7000 05 0 1 0043000 0 0 1
A 00 00000003 1 00000000 0
C 0 6000 02 0 1 003e000 0 0 1
C 0 5555 00 1 0 003d555 1 0 1
C 0 7800 fa 0 1 003f800 0 0 1
C 0 a000 00 1 0 004a000 1 0 1
C 0 7fff ee 0 1 003ffff 0 0 1
C 0 8001 00 1 0 0038001 1 0 1
C 1 6000 01 0 1 0000000 0 0 1
C 1 6800 02 0 1 0000800 0 0 1
C 1 7000 13 0 1 0005000 0 0 1
C 1 7800 0f 0 1 0005800 0 0 1
C 1 4000 00 1 0 0002000 1 0 1
C 1 6abc 00 1 0 0004abc 1 0 1
C 1 8123 00 1 0 0026123 0 0 1
C 1 bfff 00 1 0 001ffff 1 0 1
C 1 7800 10 0 1 0005800 0 0 1
C 1 b456 77 0 1 0001456 0 1 0
A 00 00000001 1 00000000 0
C 0 7000 09 0 1 0001000 0 0 1
C 1 8123 00 1 0 0026123 0 0 1
C 0 8123 00 1 0 0012123 1 0 1
A 10 00000000 1 00000000 0
C 1 4000 00 1 0 7ffffff 0 0 1

// ==== compile.f ====
+incdir+hdl
hdl/cart_cfg_pkg.sv
hdl/cart_bus_pkg.sv
hdl/cart_cfg_regs.sv
hdl/mapper_ascii16.sv
hdl/mapper_ascii8.sv
hdl/cart_slot_top.sv
bench/cart_slot_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cart_slot_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
